// File: compile.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
inst_decoder.sv
operand_bypass.sv
branch_resolver.sv
id_ex_reg.sv
id_top.sv
tb_id_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_id_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_id_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_defines.svh"

module tb_id_top import isa_pkg::*, pipe_pkg::*; ();

	localparam word_t SEED         = 32'h709f_8865;
	localparam int    CLK_PERIOD   = 4;
	localparam int    RESET_CYCLES = 16;
	localparam int    STEP_COUNT   = 150; // upper bound on run_inst calls of one cycle each
	localparam int    WATCHDOG_NS  = (RESET_CYCLES + STEP_COUNT) * CLK_PERIOD * 2;

	localparam funct_t ALU_FNS [16] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL,
		FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
	localparam opcode_t IMM_OPS [8] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};

	logic      clk;
	logic      reset_i;
	logic      stall_i;
	word_t     pc_i;
	word_t     inst_i;
	word_t     reg1_data_i;
	word_t     reg2_data_i;
	logic      ex_wreg_i;
	reg_addr_t ex_wd_i;
	word_t     ex_wdata_i;
	logic      mem_wreg_i;
	reg_addr_t mem_wd_i;
	word_t     mem_wdata_i;
	logic      reg1_read_o;
	logic      reg2_read_o;
	reg_addr_t reg1_addr_o;
	reg_addr_t reg2_addr_o;
	logic      branch_flag_o;
	word_t     branch_target_o;
	aluop_t    ex_aluop_o;
	alusel_t   ex_alusel_o;
	word_t     ex_reg1_o;
	word_t     ex_reg2_o;
	reg_addr_t ex_wd_o;
	logic      ex_wreg_o;
	word_t     ex_link_addr_o;

	word_t regfile [32];
	word_t rng_state;

	// decode model results for the instruction on inst_i
	logic         m_r1_read;
	logic         m_r2_read;
	logic         m_wreg;
	reg_addr_t    m_wd;
	aluop_t       m_aluop;
	alusel_t      m_alusel;
	word_t        m_imm;
	branch_kind_t m_kind;
	word_t        m_op1;
	word_t        m_op2;
	logic         m_flag;
	word_t        m_target;
	word_t        m_link;

	// what the ID/EX register should hold
	aluop_t    h_aluop;
	alusel_t   h_alusel;
	word_t     h_op1;
	word_t     h_op2;
	reg_addr_t h_wd;
	logic      h_wreg;
	word_t     h_link;

	id_top u_dut (.*);

	assign reg1_data_i = regfile[reg1_addr_o]; // combinational register file
	assign reg2_data_i = regfile[reg2_addr_o];

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic word_t next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic word_t r_inst(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
			shamt_t sh);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t i_inst(opcode_t op, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_inst(opcode_t op, logic [25:0] index);
		return {op, index};
	endfunction

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			report_failure($sformatf("error at %0d ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			report_failure($sformatf("error at %0d ns: %s is %0d, expected %0d",
				$time, name, got, exp));
		end
	endtask

	task automatic check_aluop(input string name, input aluop_t got, input aluop_t exp);
		if (got !== exp) begin
			report_failure($sformatf("error at %0d ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_alusel(input string name, input alusel_t got, input alusel_t exp);
		if (got !== exp) begin
			report_failure($sformatf("error at %0d ns: %s is %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("error at %0d ns: %s is %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic set_ctrl(input aluop_t op, input alusel_t sel, input logic r1,
			input logic r2, input logic wr, input reg_addr_t wd, input word_t imm,
			input branch_kind_t kind);
		m_aluop   = op;
		m_alusel  = sel;
		m_r1_read = r1;
		m_r2_read = r2;
		m_wreg    = wr;
		m_wd      = wd;
		m_imm     = imm;
		m_kind    = kind;
	endtask

	task automatic decode_model(input word_t inst);
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		reg_addr_t   link;
		shamt_t      sh;
		funct_t      fn;
		word_t       zext;
		word_t       sext;
		rs   = inst[25:21];
		rt   = inst[20:16];
		rd   = inst[15:11];
		sh   = inst[10:6];
		fn   = inst[5:0];
		link = reg_addr_t'(`LINK_REG);
		zext = {16'h0000, inst[15:0]};
		sext = {{16{inst[15]}}, inst[15:0]};
		set_ctrl(ALUOP_NOP, ALUSEL_NOP, 1'b0, 1'b0, 1'b0, rd, '0, BR_NONE);
		case (inst[31:26])
			OP_SPECIAL: begin
				if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) begin
					if (rs == 5'd0) begin
						case (fn)
							FN_SLL: set_ctrl(ALUOP_SLL, ALUSEL_SHIFT, 1'b0, 1'b1, 1'b1, rd,
								{27'd0, sh}, BR_NONE);
							FN_SRL: set_ctrl(ALUOP_SRL, ALUSEL_SHIFT, 1'b0, 1'b1, 1'b1, rd,
								{27'd0, sh}, BR_NONE);
							default: set_ctrl(ALUOP_SRA, ALUSEL_SHIFT, 1'b0, 1'b1, 1'b1, rd,
								{27'd0, sh}, BR_NONE);
						endcase
					end
				end else if (sh == 5'd0) begin
					case (fn)
						FN_AND: set_ctrl(ALUOP_AND, ALUSEL_LOGIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_OR: set_ctrl(ALUOP_OR, ALUSEL_LOGIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_XOR: set_ctrl(ALUOP_XOR, ALUSEL_LOGIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_NOR: set_ctrl(ALUOP_NOR, ALUSEL_LOGIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_SLLV: set_ctrl(ALUOP_SLL, ALUSEL_SHIFT, 1, 1, 1, rd, '0, BR_NONE);
						FN_SRLV: set_ctrl(ALUOP_SRL, ALUSEL_SHIFT, 1, 1, 1, rd, '0, BR_NONE);
						FN_SRAV: set_ctrl(ALUOP_SRA, ALUSEL_SHIFT, 1, 1, 1, rd, '0, BR_NONE);
						FN_ADD: set_ctrl(ALUOP_ADD, ALUSEL_ARITHMETIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_ADDU: set_ctrl(ALUOP_ADDU, ALUSEL_ARITHMETIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_SUB: set_ctrl(ALUOP_SUB, ALUSEL_ARITHMETIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_SUBU: set_ctrl(ALUOP_SUBU, ALUSEL_ARITHMETIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_SLT: set_ctrl(ALUOP_SLT, ALUSEL_ARITHMETIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_SLTU: set_ctrl(ALUOP_SLTU, ALUSEL_ARITHMETIC, 1, 1, 1, rd, '0, BR_NONE);
						FN_JR: set_ctrl(ALUOP_JR, ALUSEL_JUMP_BRANCH, 1, 0, 0, rd, '0, BR_JR);
						FN_JALR: set_ctrl(ALUOP_JALR, ALUSEL_JUMP_BRANCH, 1, 0, 1, rd, '0, BR_JR);
						default: ; // multiply, hi/lo and conditional moves stay a nop
					endcase
				end
			end
			OP_ORI: set_ctrl(ALUOP_OR, ALUSEL_LOGIC, 1, 0, 1, rt, zext, BR_NONE);
			OP_ANDI: set_ctrl(ALUOP_AND, ALUSEL_LOGIC, 1, 0, 1, rt, zext, BR_NONE);
			OP_XORI: set_ctrl(ALUOP_XOR, ALUSEL_LOGIC, 1, 0, 1, rt, zext, BR_NONE);
			OP_LUI: set_ctrl(ALUOP_OR, ALUSEL_LOGIC, 1, 0, 1, rt, {inst[15:0], 16'h0000},
				BR_NONE);
			OP_ADDI: set_ctrl(ALUOP_ADDI, ALUSEL_ARITHMETIC, 1, 0, 1, rt, sext, BR_NONE);
			OP_ADDIU: set_ctrl(ALUOP_ADDIU, ALUSEL_ARITHMETIC, 1, 0, 1, rt, sext, BR_NONE);
			OP_SLTI: set_ctrl(ALUOP_SLT, ALUSEL_ARITHMETIC, 1, 0, 1, rt, sext, BR_NONE);
			OP_SLTIU: set_ctrl(ALUOP_SLTU, ALUSEL_ARITHMETIC, 1, 0, 1, rt, sext, BR_NONE);
			OP_J: set_ctrl(ALUOP_J, ALUSEL_JUMP_BRANCH, 0, 0, 0, link, '0, BR_J);
			OP_JAL: set_ctrl(ALUOP_JAL, ALUSEL_JUMP_BRANCH, 0, 0, 1, link, '0, BR_J);
			OP_BEQ: set_ctrl(ALUOP_BEQ, ALUSEL_JUMP_BRANCH, 1, 1, 0, rd, '0, BR_BEQ);
			OP_BNE: set_ctrl(ALUOP_BNE, ALUSEL_JUMP_BRANCH, 1, 1, 0, rd, '0, BR_BNE);
			OP_BGTZ: set_ctrl(ALUOP_BGTZ, ALUSEL_JUMP_BRANCH, 1, 0, 0, rd, '0, BR_BGTZ);
			OP_BLEZ: set_ctrl(ALUOP_BLEZ, ALUSEL_JUMP_BRANCH, 1, 0, 0, rd, '0, BR_BLEZ);
			OP_REGIMM: begin
				case (rt)
					RT_BLTZ: set_ctrl(ALUOP_BLTZ, ALUSEL_JUMP_BRANCH, 1, 0, 0, link, '0, BR_BLTZ);
					RT_BGEZ: set_ctrl(ALUOP_BGEZ, ALUSEL_JUMP_BRANCH, 1, 0, 0, link, '0, BR_BGEZ);
					RT_BLTZAL: set_ctrl(ALUOP_BLTZAL, ALUSEL_JUMP_BRANCH, 1, 0, 1, link, '0,
						BR_BLTZ);
					RT_BGEZAL: set_ctrl(ALUOP_BGEZAL, ALUSEL_JUMP_BRANCH, 1, 0, 1, link, '0,
						BR_BGEZ);
					default: ;
				endcase
			end
			default: ; // loads, stores and unknown opcodes
		endcase
	endtask

	function automatic word_t expect_operand(logic read, reg_addr_t addr, word_t imm);
		if (!read) begin
			return imm;
		end
		if (ex_wreg_i && ex_wd_i == addr) begin
			return ex_wdata_i;
		end
		if (mem_wreg_i && mem_wd_i == addr) begin
			return mem_wdata_i;
		end
		return regfile[addr];
	endfunction

	task automatic model_branch(input word_t pc, input word_t inst);
		word_t seq;
		seq      = pc + `PC_NEXT_OFFSET;
		m_link   = pc + `PC_LINK_OFFSET;
		m_flag   = 1'b0;
		m_target = '0;
		case (m_kind)
			BR_BEQ: m_flag = (m_op1 == m_op2);
			BR_BNE: m_flag = (m_op1 != m_op2);
			BR_BGTZ: m_flag = ($signed(m_op1) > 0);
			BR_BLEZ: m_flag = ($signed(m_op1) <= 0);
			BR_BGEZ: m_flag = ($signed(m_op1) >= 0);
			BR_BLTZ: m_flag = ($signed(m_op1) < 0);
			BR_J, BR_JR: m_flag = 1'b1;
			default: m_flag = 1'b0;
		endcase
		if (m_flag) begin
			case (m_kind)
				BR_J: m_target = {seq[31:28], inst[25:0], 2'b00};
				BR_JR: m_target = m_op1;
				default: m_target = seq + {{14{inst[15]}}, inst[15:0], 2'b00};
			endcase
		end
	endtask

	task automatic check_ex_stage();
		check_aluop("ex_aluop_o", ex_aluop_o, h_aluop);
		check_alusel("ex_alusel_o", ex_alusel_o, h_alusel);
		check_word("ex_reg1_o", ex_reg1_o, h_op1);
		check_word("ex_reg2_o", ex_reg2_o, h_op2);
		check_bit("ex_wreg_o", ex_wreg_o, h_wreg);
		if (h_wreg) begin
			check_addr("ex_wd_o", ex_wd_o, h_wd);
		end
		check_word("ex_link_addr_o", ex_link_addr_o, h_link);
	endtask

	// starts and ends on a falling edge
	task automatic run_inst(input word_t pc, input word_t inst);
		pc_i   = pc;
		inst_i = inst;
		#1;
		decode_model(inst);
		m_op1 = expect_operand(m_r1_read, inst[25:21], m_imm);
		m_op2 = expect_operand(m_r2_read, inst[20:16], m_imm);
		model_branch(pc, inst);
		check_bit("reg1_read_o", reg1_read_o, m_r1_read);
		check_bit("reg2_read_o", reg2_read_o, m_r2_read);
		if (m_r1_read) begin
			check_addr("reg1_addr_o", reg1_addr_o, inst[25:21]);
		end
		if (m_r2_read) begin
			check_addr("reg2_addr_o", reg2_addr_o, inst[20:16]);
		end
		check_bit("branch_flag_o", branch_flag_o, m_flag);
		check_word("branch_target_o", branch_target_o, m_target);
		@(posedge clk);
		if (!stall_i) begin
			h_aluop  = m_aluop;
			h_alusel = m_alusel;
			h_op1    = m_op1;
			h_op2    = m_op2;
			h_wd     = m_wd;
			h_wreg   = m_wreg;
			h_link   = m_link;
		end
		@(negedge clk);
		check_ex_stage();
	endtask

	task automatic set_forward(input logic ex_we, input reg_addr_t ex_a, input logic mem_we,
			input reg_addr_t mem_a);
		ex_wreg_i   = ex_we;
		ex_wd_i     = ex_a;
		ex_wdata_i  = next_random();
		mem_wreg_i  = mem_we;
		mem_wd_i    = mem_a;
		mem_wdata_i = next_random();
	endtask

	task automatic test_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		check_bit("ex_wreg_o", ex_wreg_o, 1'b0);
		check_aluop("ex_aluop_o", ex_aluop_o, ALUOP_NOP);
		check_alusel("ex_alusel_o", ex_alusel_o, ALUSEL_NOP);
		check_word("ex_reg1_o", ex_reg1_o, '0);
		check_word("ex_reg2_o", ex_reg2_o, '0);
		check_addr("ex_wd_o", ex_wd_o, '0);
		check_word("ex_link_addr_o", ex_link_addr_o, '0);
	endtask

	task automatic test_alu_decode();
		word_t  r;
		funct_t fn;
		int     k;
		set_forward(1'b0, 5'd0, 1'b0, 5'd0);
		for (k = 0; k < 32; k++) begin
			r  = next_random();
			fn = ALU_FNS[k % 16];
			if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) begin
				run_inst(next_random() & 32'hffff_fffc,
					r_inst(fn, 5'd0, r[4:0], r[9:5], r[14:10] | 5'd1));
			end else begin
				run_inst(next_random() & 32'hffff_fffc,
					r_inst(fn, r[4:0], r[9:5], r[14:10], 5'd0));
			end
		end
		for (k = 0; k < 16; k++) begin
			r = next_random();
			// even k gets a negative immediate
			run_inst(next_random() & 32'hffff_fffc,
				i_inst(IMM_OPS[k / 2], r[20:16], r[25:21], {~k[0], r[14:0]}));
		end
	endtask

	task automatic test_forwarding();
		word_t inst;
		inst = r_inst(FN_ADD, 5'd5, 5'd9, 5'd10, 5'd0);
		set_forward(1'b1, 5'd5, 1'b1, 5'd5); // execute beats memory
		run_inst(32'h0000_0400, inst);
		set_forward(1'b0, 5'd5, 1'b1, 5'd5);
		run_inst(32'h0000_0404, inst);
		set_forward(1'b1, 5'd9, 1'b1, 5'd9);
		run_inst(32'h0000_0408, inst);
		set_forward(1'b1, 5'd12, 1'b1, 5'd13);
		run_inst(32'h0000_040c, inst);
		set_forward(1'b1, 5'd5, 1'b1, 5'd9);
		run_inst(32'h0000_0410, inst);
		set_forward(1'b0, 5'd5, 1'b0, 5'd9); // matching address without write enable
		run_inst(32'h0000_0414, inst);
	endtask

	task automatic test_branches();
		word_t r;
		word_t v;
		word_t inst;
		int    k;
		set_forward(1'b1, 5'd3, 1'b1, 5'd7); // rs from execute, rt from memory
		for (k = 0; k < 8; k++) begin
			r           = next_random();
			v           = next_random();
			ex_wdata_i  = v;
			mem_wdata_i = k[0] ? v : ~v;
			run_inst(next_random() & 32'hffff_fffc,
				i_inst((k < 4) ? OP_BEQ : OP_BNE, 5'd3, 5'd7, r[15:0]));
		end
		for (k = 0; k < 18; k++) begin
			r = next_random();
			case (k % 3)
				0: v = {1'b0, r[30:1], 1'b1};
				1: v = '0;
				default: v = {1'b1, r[30:0]};
			endcase
			ex_wdata_i = v;
			case (k / 3)
				0: inst = i_inst(OP_BGTZ, 5'd3, 5'd0, r[15:0]);
				1: inst = i_inst(OP_BLEZ, 5'd3, 5'd0, r[15:0]);
				2: inst = i_inst(OP_REGIMM, 5'd3, RT_BGEZ, r[15:0]);
				3: inst = i_inst(OP_REGIMM, 5'd3, RT_BLTZ, r[15:0]);
				4: inst = i_inst(OP_REGIMM, 5'd3, RT_BGEZAL, r[15:0]);
				default: inst = i_inst(OP_REGIMM, 5'd3, RT_BLTZAL, r[15:0]);
			endcase
			run_inst(next_random() & 32'hffff_fffc, inst);
		end
		for (k = 0; k < 8; k++) begin
			r          = next_random();
			ex_wdata_i = next_random() & 32'hffff_fffc; // jump register target
			case (k % 4)
				0: inst = j_inst(OP_J, r[25:0]);
				1: inst = j_inst(OP_JAL, r[25:0]);
				2: inst = r_inst(FN_JR, 5'd3, 5'd0, 5'd0, 5'd0);
				default: inst = r_inst(FN_JALR, 5'd3, 5'd0, r[30:26], 5'd0);
			endcase
			run_inst(next_random() & 32'hffff_fffc, inst);
		end
	endtask

	task automatic test_stall();
		word_t r;
		int    k;
		set_forward(1'b0, 5'd0, 1'b0, 5'd0);
		r = next_random();
		run_inst(32'h0000_2000, i_inst(OP_ADDI, r[4:0], r[9:5], r[25:10]));
		stall_i = 1'b1;
		for (k = 0; k < 3; k++) begin
			r = next_random();
			run_inst(next_random() & 32'hffff_fffc, r_inst(FN_XOR, r[4:0], r[9:5], r[14:10], 5'd0));
		end
		stall_i = 1'b0;
		r = next_random();
		run_inst(32'h0000_2010, i_inst(OP_LUI, r[4:0], r[9:5], r[25:10]));
	endtask

	task automatic test_dropped();
		word_t r;
		r = next_random();
		run_inst(32'h0000_3000, {6'b100011, r[25:0]}); // lw
		run_inst(32'h0000_3004, {6'b101011, r[25:0]}); // sw
		run_inst(32'h0000_3008, r_inst(6'b011000, r[4:0], r[9:5], 5'd0, 5'd0)); // mult
		run_inst(32'h0000_300c, r_inst(6'b010000, 5'd0, 5'd0, r[14:10], 5'd0)); // mfhi
		run_inst(32'h0000_3010, r_inst(6'b001011, r[4:0], r[9:5], r[14:10], 5'd0)); // movn
		run_inst(32'h0000_3014, {6'b011100, r[25:0]}); // madd, clz
		run_inst(32'h0000_3018, {OP_REGIMM, r[25:21], 5'b00010, r[15:0]});
		run_inst(32'h0000_301c, {6'b111111, r[25:0]});
		run_inst(32'h0000_3020, r_inst(FN_ADD, r[4:0], r[9:5], r[14:10], 5'd3)); // bad shamt
	endtask

	initial begin
		#(WATCHDOG_NS);
		report_failure("timeout: the tests did not finish within the expected time");
	end

	initial begin
		int k;
		rng_state   = SEED;
		clk         = 1'b0;
		reset_i     = 1'b1;
		stall_i     = 1'b0;
		pc_i        = 32'h0000_1000;
		inst_i      = i_inst(OP_ORI, 5'd1, 5'd2, 16'h1234); // would load if reset failed
		ex_wreg_i   = 1'b0;
		ex_wd_i     = '0;
		ex_wdata_i  = '0;
		mem_wreg_i  = 1'b0;
		mem_wd_i    = '0;
		mem_wdata_i = '0;
		for (k = 0; k < 32; k++) begin
			regfile[k] = next_random();
		end
		h_aluop  = ALUOP_NOP;
		h_alusel = ALUSEL_NOP;
		h_op1    = '0;
		h_op2    = '0;
		h_wd     = '0;
		h_wreg   = 1'b0;
		h_link   = '0;
		test_reset();
		test_alu_decode();
		test_forwarding();
		test_branches();
		test_stall();
		test_dropped();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: id_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_defines.svh"

module id_top import isa_pkg::*, pipe_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      stall_i,
	input  word_t     pc_i,
	input  word_t     inst_i,
	input  word_t     reg1_data_i,
	input  word_t     reg2_data_i,
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	output logic      reg1_read_o,
	output logic      reg2_read_o,
	output reg_addr_t reg1_addr_o,
	output reg_addr_t reg2_addr_o,
	output logic      branch_flag_o,
	output word_t     branch_target_o,
	output aluop_t    ex_aluop_o,
	output alusel_t   ex_alusel_o,
	output word_t     ex_reg1_o,
	output word_t     ex_reg2_o,
	output reg_addr_t ex_wd_o,
	output logic      ex_wreg_o,
	output word_t     ex_link_addr_o
);

	reg_addr_t    wd;
	logic         wreg;
	aluop_t       aluop;
	alusel_t      alusel;
	word_t        imm;
	branch_kind_t branch_kind;
	word_t        reg1;
	word_t        reg2;
	word_t        link_addr;

	inst_decoder u_decoder (
		.inst_i        (inst_i),
		.reg1_read_o   (reg1_read_o),
		.reg2_read_o   (reg2_read_o),
		.reg1_addr_o   (reg1_addr_o),
		.reg2_addr_o   (reg2_addr_o),
		.wd_o          (wd),
		.wreg_o        (wreg),
		.aluop_o       (aluop),
		.alusel_o      (alusel),
		.imm_o         (imm),
		.branch_kind_o (branch_kind)
	);

	operand_bypass u_bypass1 (
		.read_i      (reg1_read_o),
		.addr_i      (reg1_addr_o),
		.reg_data_i  (reg1_data_i),
		.imm_i       (imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (reg1)
	);

	operand_bypass u_bypass2 (
		.read_i      (reg2_read_o),
		.addr_i      (reg2_addr_o),
		.reg_data_i  (reg2_data_i),
		.imm_i       (imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (reg2)
	);

	branch_resolver u_branch (
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.reg1_i          (reg1),
		.reg2_i          (reg2),
		.branch_kind_i   (branch_kind),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr)
	);

	id_ex_reg u_id_ex (
		.clk            (clk),
		.reset_i        (reset_i),
		.stall_i        (stall_i),
		.aluop_i        (aluop),
		.alusel_i       (alusel),
		.reg1_i         (reg1),
		.reg2_i         (reg2),
		.wd_i           (wd),
		.wreg_i         (wreg),
		.link_addr_i    (link_addr),
		.ex_aluop_o     (ex_aluop_o),
		.ex_alusel_o    (ex_alusel_o),
		.ex_reg1_o      (ex_reg1_o),
		.ex_reg2_o      (ex_reg2_o),
		.ex_wd_o        (ex_wd_o),
		.ex_wreg_o      (ex_wreg_o),
		.ex_link_addr_o (ex_link_addr_o)
	);

endmodule

`default_nettype wire

// File: id_ex_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg import isa_pkg::*, pipe_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      stall_i,
	input  aluop_t    aluop_i,
	input  alusel_t   alusel_i,
	input  word_t     reg1_i,
	input  word_t     reg2_i,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	input  word_t     link_addr_i,
	output aluop_t    ex_aluop_o,
	output alusel_t   ex_alusel_o,
	output word_t     ex_reg1_o,
	output word_t     ex_reg2_o,
	output reg_addr_t ex_wd_o,
	output logic      ex_wreg_o,
	output word_t     ex_link_addr_o
);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_aluop_o     <= ALUOP_NOP;
			ex_alusel_o    <= ALUSEL_NOP;
			ex_reg1_o      <= '0;
			ex_reg2_o      <= '0;
			ex_wd_o        <= '0;
			ex_wreg_o      <= 1'b0;
			ex_link_addr_o <= '0;
		end else if (!stall_i) begin
			ex_aluop_o     <= aluop_i;
			ex_alusel_o    <= alusel_i;
			ex_reg1_o      <= reg1_i;
			ex_reg2_o      <= reg2_i;
			ex_wd_o        <= wd_i;
			ex_wreg_o      <= wreg_i;
			ex_link_addr_o <= link_addr_i; // only meaningful for linking jumps
		end
	end

endmodule

`default_nettype wire

// File: branch_resolver.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_defines.svh"

module branch_resolver import isa_pkg::*, pipe_pkg::*; (
	input  word_t        pc_i,
	input  word_t        inst_i,
	input  word_t        reg1_i,
	input  word_t        reg2_i,
	input  branch_kind_t branch_kind_i,
	output logic         branch_flag_o,
	output word_t        branch_target_o,
	output word_t        link_addr_o
);

	word_t pc_next;
	word_t br_target;
	word_t jump_target;
	word_t target;
	logic  taken;
	logic  reg1_neg;
	logic  reg1_zero;

	assign pc_next     = pc_i + `PC_NEXT_OFFSET;
	assign link_addr_o = pc_i + `PC_LINK_OFFSET;

	assign br_target   = pc_next + word_t'(signed'({inst_i[15:0], 2'b00}));
	assign jump_target = {pc_next[`WORD_WIDTH-1 -: 4], inst_i[25:0], 2'b00}; // same 256MB region

	assign reg1_neg  = reg1_i[`WORD_WIDTH-1];
	assign reg1_zero = (reg1_i == '0);

	always_comb begin
		taken  = 1'b0;
		target = br_target;
		case (branch_kind_i)
			BR_BEQ: taken = (reg1_i == reg2_i);
			BR_BNE: taken = (reg1_i != reg2_i);
			BR_BGTZ: taken = !reg1_neg && !reg1_zero;
			BR_BLEZ: taken = reg1_neg || reg1_zero;
			BR_BGEZ: taken = !reg1_neg;
			BR_BLTZ: taken = reg1_neg;
			BR_J: begin
				taken  = 1'b1;
				target = jump_target;
			end
			BR_JR: begin
				taken  = 1'b1;
				target = reg1_i; // already forwarded
			end
			default: taken = 1'b0;
		endcase
	end

	assign branch_flag_o   = taken;
	assign branch_target_o = taken ? target : '0;

endmodule

`default_nettype wire

// File: operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass import isa_pkg::*; (
	input  logic      read_i,
	input  reg_addr_t addr_i,
	input  word_t     reg_data_i,
	input  word_t     imm_i,
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	output word_t     operand_o
);

	logic ex_hit;
	logic mem_hit;

	// no special case for r0, a write to it still forwards
	assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
	assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

	always_comb begin
		if (!read_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_wdata_i; // youngest result wins
		end else if (mem_hit) begin
			operand_o = mem_wdata_i;
		end else begin
			operand_o = reg_data_i;
		end
	end

endmodule

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_defines.svh"

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
	input  word_t        inst_i,
	output logic         reg1_read_o,
	output logic         reg2_read_o,
	output reg_addr_t    reg1_addr_o,
	output reg_addr_t    reg2_addr_o,
	output reg_addr_t    wd_o,
	output logic         wreg_o,
	output aluop_t       aluop_o,
	output alusel_t      alusel_o,
	output word_t        imm_o,
	output branch_kind_t branch_kind_o
);

	opcode_t     opcode;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	shamt_t      shamt;
	funct_t      funct;
	logic [15:0] imm16;
	logic        shift_imm;
	logic        special_ok;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	assign reg1_addr_o = rs;
	assign reg2_addr_o = rt;

	assign shift_imm  = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);
	assign special_ok = shift_imm ? (rs == '0) : (shamt == '0); // unused fields must be zero

	always_comb begin
		aluop_o       = ALUOP_NOP;
		alusel_o      = ALUSEL_NOP;
		reg1_read_o   = 1'b0;
		reg2_read_o   = 1'b0;
		wreg_o        = 1'b0;
		wd_o          = rd;
		imm_o         = '0;
		branch_kind_o = BR_NONE;
		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_AND: aluop_o = ALUOP_AND;
					FN_OR: aluop_o = ALUOP_OR;
					FN_XOR: aluop_o = ALUOP_XOR;
					FN_NOR: aluop_o = ALUOP_NOR;
					FN_SLL, FN_SLLV: aluop_o = ALUOP_SLL;
					FN_SRL, FN_SRLV: aluop_o = ALUOP_SRL;
					FN_SRA, FN_SRAV: aluop_o = ALUOP_SRA;
					FN_ADD: aluop_o = ALUOP_ADD;
					FN_ADDU: aluop_o = ALUOP_ADDU;
					FN_SUB: aluop_o = ALUOP_SUB;
					FN_SUBU: aluop_o = ALUOP_SUBU;
					FN_SLT: aluop_o = ALUOP_SLT;
					FN_SLTU: aluop_o = ALUOP_SLTU;
					FN_JR: aluop_o = ALUOP_JR;
					FN_JALR: aluop_o = ALUOP_JALR;
					default: aluop_o = ALUOP_NOP; // mult, mfhi, movn etc
				endcase
				case (funct)
					FN_AND, FN_OR, FN_XOR, FN_NOR: alusel_o = ALUSEL_LOGIC;
					FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: alusel_o = ALUSEL_SHIFT;
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: alusel_o = ALUSEL_ARITHMETIC;
					FN_JR, FN_JALR: alusel_o = ALUSEL_JUMP_BRANCH;
					default: alusel_o = ALUSEL_NOP;
				endcase
				if (!special_ok) begin
					aluop_o  = ALUOP_NOP;
					alusel_o = ALUSEL_NOP;
				end else if (alusel_o != ALUSEL_NOP) begin
					reg1_read_o = !shift_imm; // sll/srl/sra shift rt by shamt
					reg2_read_o = (alusel_o != ALUSEL_JUMP_BRANCH);
					wreg_o      = (funct != FN_JR);
					if (shift_imm) begin
						imm_o = word_t'(shamt);
					end
					if (alusel_o == ALUSEL_JUMP_BRANCH) begin
						branch_kind_o = BR_JR;
					end
				end
			end
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
				alusel_o    = ALUSEL_LOGIC;
				reg1_read_o = 1'b1;
				wreg_o      = 1'b1;
				wd_o        = rt;
				imm_o       = (opcode == OP_LUI) ? {imm16, 16'h0000} : word_t'(imm16);
				if (opcode == OP_ANDI) begin
					aluop_o = ALUOP_AND;
				end else if (opcode == OP_XORI) begin
					aluop_o = ALUOP_XOR;
				end else begin
					aluop_o = ALUOP_OR; // lui ors into rs
				end
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				alusel_o    = ALUSEL_ARITHMETIC;
				reg1_read_o = 1'b1;
				wreg_o      = 1'b1;
				wd_o        = rt;
				imm_o       = word_t'(signed'(imm16)); // sign extend, sltiu too
				case (opcode)
					OP_ADDI: aluop_o = ALUOP_ADDI;
					OP_ADDIU: aluop_o = ALUOP_ADDIU;
					OP_SLTI: aluop_o = ALUOP_SLT;
					default: aluop_o = ALUOP_SLTU;
				endcase
			end
			OP_J, OP_JAL: begin
				alusel_o      = ALUSEL_JUMP_BRANCH;
				branch_kind_o = BR_J;
				aluop_o       = (opcode == OP_JAL) ? ALUOP_JAL : ALUOP_J;
				wreg_o        = (opcode == OP_JAL);
				wd_o          = reg_addr_t'(`LINK_REG);
			end
			OP_BEQ, OP_BNE: begin
				alusel_o      = ALUSEL_JUMP_BRANCH;
				reg1_read_o   = 1'b1;
				reg2_read_o   = 1'b1;
				aluop_o       = (opcode == OP_BEQ) ? ALUOP_BEQ : ALUOP_BNE;
				branch_kind_o = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
			end
			OP_BGTZ, OP_BLEZ: begin
				alusel_o      = ALUSEL_JUMP_BRANCH;
				reg1_read_o   = 1'b1;
				aluop_o       = (opcode == OP_BGTZ) ? ALUOP_BGTZ : ALUOP_BLEZ;
				branch_kind_o = (opcode == OP_BGTZ) ? BR_BGTZ : BR_BLEZ;
			end
			OP_REGIMM: begin
				if (rt == RT_BGEZ || rt == RT_BGEZAL || rt == RT_BLTZ || rt == RT_BLTZAL) begin
					alusel_o      = ALUSEL_JUMP_BRANCH;
					reg1_read_o   = 1'b1;
					wd_o          = reg_addr_t'(`LINK_REG);
					wreg_o        = (rt == RT_BGEZAL) || (rt == RT_BLTZAL);
					branch_kind_o = (rt == RT_BGEZ || rt == RT_BGEZAL) ? BR_BGEZ : BR_BLTZ;
					case (rt)
						RT_BGEZ: aluop_o = ALUOP_BGEZ;
						RT_BGEZAL: aluop_o = ALUOP_BGEZAL;
						RT_BLTZ: aluop_o = ALUOP_BLTZ;
						default: aluop_o = ALUOP_BLTZAL;
					endcase
				end
			end
			default: begin
				aluop_o = ALUOP_NOP; // loads, stores, special2, unknown
			end
		endcase
	end

endmodule

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	typedef logic [7:0] aluop_t;
	typedef logic [2:0] alusel_t;
	typedef logic [3:0] branch_kind_t;

	localparam aluop_t ALUOP_NOP    = 8'b00000000;
	localparam aluop_t ALUOP_AND    = 8'b00100100;
	localparam aluop_t ALUOP_OR     = 8'b00100101;
	localparam aluop_t ALUOP_XOR    = 8'b00100110;
	localparam aluop_t ALUOP_NOR    = 8'b00100111;
	localparam aluop_t ALUOP_SLL    = 8'b01111100;
	localparam aluop_t ALUOP_SRL    = 8'b00000010;
	localparam aluop_t ALUOP_SRA    = 8'b00000011;
	localparam aluop_t ALUOP_ADD    = 8'b00100000;
	localparam aluop_t ALUOP_ADDU   = 8'b00100001;
	localparam aluop_t ALUOP_SUB    = 8'b00100010;
	localparam aluop_t ALUOP_SUBU   = 8'b00100011;
	localparam aluop_t ALUOP_SLT    = 8'b00101010;
	localparam aluop_t ALUOP_SLTU   = 8'b00101011;
	localparam aluop_t ALUOP_ADDI   = 8'b01010101;
	localparam aluop_t ALUOP_ADDIU  = 8'b01010110;
	localparam aluop_t ALUOP_J      = 8'b01001111;
	localparam aluop_t ALUOP_JAL    = 8'b01010000;
	localparam aluop_t ALUOP_JR     = 8'b00001000;
	localparam aluop_t ALUOP_JALR   = 8'b00001001;
	localparam aluop_t ALUOP_BEQ    = 8'b01010001;
	localparam aluop_t ALUOP_BNE    = 8'b01010010;
	localparam aluop_t ALUOP_BLEZ   = 8'b01010011;
	localparam aluop_t ALUOP_BGTZ   = 8'b01010100;
	localparam aluop_t ALUOP_BGEZ   = 8'b01000001;
	localparam aluop_t ALUOP_BLTZ   = 8'b01000000;
	localparam aluop_t ALUOP_BGEZAL = 8'b01001011;
	localparam aluop_t ALUOP_BLTZAL = 8'b01001010;

	// result class picked in execute
	localparam alusel_t ALUSEL_NOP         = 3'b000;
	localparam alusel_t ALUSEL_LOGIC       = 3'b001;
	localparam alusel_t ALUSEL_SHIFT       = 3'b010;
	localparam alusel_t ALUSEL_ARITHMETIC  = 3'b100;
	localparam alusel_t ALUSEL_JUMP_BRANCH = 3'b110;

	localparam branch_kind_t BR_NONE = 4'd0;
	localparam branch_kind_t BR_BEQ  = 4'd1;
	localparam branch_kind_t BR_BNE  = 4'd2;
	localparam branch_kind_t BR_BGTZ = 4'd3;
	localparam branch_kind_t BR_BLEZ = 4'd4;
	localparam branch_kind_t BR_BGEZ = 4'd5;
	localparam branch_kind_t BR_BLTZ = 4'd6;
	localparam branch_kind_t BR_J    = 4'd7; // j and jal, index target
	localparam branch_kind_t BR_JR   = 4'd8; // jr and jalr, register target

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

`include "mips_defines.svh"

package isa_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] shamt_t;

	// primary opcodes
	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_REGIMM  = 6'b000001;
	localparam opcode_t OP_J       = 6'b000010;
	localparam opcode_t OP_JAL     = 6'b000011;
	localparam opcode_t OP_BEQ     = 6'b000100;
	localparam opcode_t OP_BNE     = 6'b000101;
	localparam opcode_t OP_BLEZ    = 6'b000110;
	localparam opcode_t OP_BGTZ    = 6'b000111;
	localparam opcode_t OP_ADDI    = 6'b001000;
	localparam opcode_t OP_ADDIU   = 6'b001001;
	localparam opcode_t OP_SLTI    = 6'b001010;
	localparam opcode_t OP_SLTIU   = 6'b001011;
	localparam opcode_t OP_ANDI    = 6'b001100;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_XORI    = 6'b001110;
	localparam opcode_t OP_LUI     = 6'b001111;

	// SPECIAL function field
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;
	localparam funct_t FN_SLLV = 6'b000100;
	localparam funct_t FN_SRLV = 6'b000110;
	localparam funct_t FN_SRAV = 6'b000111;
	localparam funct_t FN_JR   = 6'b001000;
	localparam funct_t FN_JALR = 6'b001001;
	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_NOR  = 6'b100111;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

	// REGIMM codes live in the rt field
	localparam reg_addr_t RT_BLTZ   = 5'b00000;
	localparam reg_addr_t RT_BGEZ   = 5'b00001;
	localparam reg_addr_t RT_BLTZAL = 5'b10000;
	localparam reg_addr_t RT_BGEZAL = 5'b10001;

endpackage

`default_nettype wire

// File: mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath and address width
`define WORD_WIDTH 32

// register file index width
`define REG_ADDR_WIDTH 5

// destination for jal, bgezal and bltzal
`define LINK_REG 31

// sequential fetch step
`define PC_NEXT_OFFSET 4

// return address skips the slot after the jump
`define PC_LINK_OFFSET 8

`endif
